// ==== hw/conv_defines.svh ====
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// Fixed point word, Q16.15 two's complement
`define CONV_DATA_W 32
`define CONV_FRAC_W 15

// Layer geometry
`define CONV_IN_SIZE 6
`define CONV_IN_DEPTH 2
`define CONV_KERNEL 3
`define CONV_OUT_DEPTH 2
`define CONV_POOL 2
`define CONV_OUT_SIZE (`CONV_IN_SIZE - `CONV_KERNEL + 1)
`define CONV_POOL_SIZE (`CONV_OUT_SIZE / `CONV_POOL)

// Index widths
`define CONV_COORD_W 3
`define CONV_CH_W 1
`define CONV_KOFF_W 2

// Weight address is {out ch, in ch, kx, ky}
`define CONV_WT_ADDR_W (2 * `CONV_CH_W + 2 * `CONV_KOFF_W)
// Accumulator address is ch * out_size^2 + x * out_size + y
`define CONV_ACC_ADDR_W $clog2(`CONV_OUT_DEPTH * `CONV_OUT_SIZE * `CONV_OUT_SIZE)

`endif

// ==== hw/conv_pkg.sv ====
`include "conv_defines.svh"

package conv_pkg;

    // One feature value with its position
    typedef struct packed {
        logic [`CONV_DATA_W-1:0]  data;
        logic [`CONV_CH_W-1:0]    ch;
        logic [`CONV_COORD_W-1:0] x;
        logic [`CONV_COORD_W-1:0] y;
    } feature_t;

    // One weight load
    typedef struct packed {
        logic [`CONV_DATA_W-1:0] data;
        logic [`CONV_CH_W-1:0]   out_ch;
        logic [`CONV_CH_W-1:0]   in_ch;
        logic [`CONV_KOFF_W-1:0] kx;
        logic [`CONV_KOFF_W-1:0] ky;
    } weight_wr_t;

    // Pooled result, coordinates are in the pooled grid
    typedef struct packed {
        logic [`CONV_DATA_W-1:0]  data;
        logic [`CONV_CH_W-1:0]    ch;
        logic [`CONV_COORD_W-1:0] x;
        logic [`CONV_COORD_W-1:0] y;
    } pool_out_t;

    typedef struct packed {
        logic                        en;
        logic [`CONV_ACC_ADDR_W-1:0] addr;
    } acc_rd_t;

    typedef struct packed {
        logic                        en;
        logic [`CONV_ACC_ADDR_W-1:0] addr;
        logic [`CONV_DATA_W-1:0]     data;
    } acc_wr_t;

    typedef enum logic {OWNER_ENGINE, OWNER_SCANNER} acc_owner_e;

    typedef enum logic [1:0] {ENG_RECV, ENG_READ, ENG_WRITE, ENG_NEXT} engine_state_e;

    typedef enum logic [1:0] {SCAN_READ, SCAN_CLEAR, SCAN_SEND, SCAN_IDLE} scan_state_e;

endpackage

// ==== hw/conv_weight_ram.sv ====
`timescale 1ns/100ps
`include "conv_defines.svh"

module conv_weight_ram (
    input  logic                          clk,
    input  logic                          i_wt_valid,
    input  conv_pkg::weight_wr_t          i_wt,
    input  logic [`CONV_WT_ADDR_W-1:0]    i_rd_addr,
    output logic [`CONV_DATA_W-1:0]       o_rd_data
);
    import conv_pkg::*;

    localparam int WT_DEPTH = 2 ** `CONV_WT_ADDR_W;

    logic [`CONV_DATA_W-1:0]    mem [WT_DEPTH];
    logic [`CONV_WT_ADDR_W-1:0] wr_addr;

    // Same field order the engine uses when it reads
    assign wr_addr = {i_wt.out_ch, i_wt.in_ch, i_wt.kx, i_wt.ky};

    // Load port, no handshake
    always_ff @(posedge clk) begin
        if (i_wt_valid) begin
            mem[wr_addr] <= i_wt.data;
        end
    end

    // Engine read, data one cycle after the address
    always_ff @(posedge clk) begin
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

// ==== hw/conv_acc_ram.sv ====
`timescale 1ns/100ps
`include "conv_defines.svh"

module conv_acc_ram (
    input  logic                    clk,
    input  conv_pkg::acc_rd_t       i_rd,
    input  conv_pkg::acc_wr_t       i_wr,
    output logic [`CONV_DATA_W-1:0] o_rd_data
);
    import conv_pkg::*;

    localparam int ACC_DEPTH = `CONV_OUT_DEPTH * `CONV_OUT_SIZE * `CONV_OUT_SIZE;

    logic [`CONV_DATA_W-1:0] mem [ACC_DEPTH];
    logic                    same_addr;

    assign same_addr = i_wr.en && (i_wr.addr == i_rd.addr);

    always_ff @(posedge clk) begin
        if (i_wr.en) begin
            mem[i_wr.addr] <= i_wr.data;
        end
    end

    // Write-first on a same-address collision
    always_ff @(posedge clk) begin
        if (i_rd.en) begin
            if (same_addr) begin
                o_rd_data <= i_wr.data;
            end else begin
                o_rd_data <= mem[i_rd.addr];
            end
        end
    end

endmodule

// ==== hw/conv_acc_arbiter.sv ====
`timescale 1ns/100ps
`include "conv_defines.svh"

module conv_acc_arbiter (
    input  logic              clk,
    input  logic              i_reset,
    input  conv_pkg::acc_rd_t i_eng_rd,
    input  conv_pkg::acc_wr_t i_eng_wr,
    input  conv_pkg::acc_rd_t i_scan_rd,
    input  conv_pkg::acc_wr_t i_scan_wr,
    input  logic              i_frame_done,
    input  logic              i_scan_done,
    output logic              o_eng_grant,
    output logic              o_scan_grant,
    output conv_pkg::acc_rd_t o_ram_rd,
    output conv_pkg::acc_wr_t o_ram_wr
);
    import conv_pkg::*;

    acc_owner_e owner;

    // Frame phase: accumulate, then sweep
    always_ff @(posedge clk) begin
        if (i_reset) begin
            owner <= OWNER_ENGINE;
        end else if (i_frame_done) begin
            owner <= OWNER_SCANNER;
        end else if (i_scan_done) begin
            owner <= OWNER_ENGINE;
        end
    end

    assign o_eng_grant  = (owner == OWNER_ENGINE);
    assign o_scan_grant = (owner == OWNER_SCANNER);

    // Only the owner reaches the RAM
    assign o_ram_rd = o_eng_grant ? i_eng_rd : i_scan_rd;
    assign o_ram_wr = o_eng_grant ? i_eng_wr : i_scan_wr;

    // Neither side touches the memory without a grant
    a_eng_owns: assert property (@(posedge clk) disable iff (i_reset)
        (i_eng_rd.en || i_eng_wr.en) |-> owner == OWNER_ENGINE);

    a_scan_owns: assert property (@(posedge clk) disable iff (i_reset)
        (i_scan_rd.en || i_scan_wr.en) |-> owner == OWNER_SCANNER);

    // A handover never overlaps the one going the other way
    a_done_apart: assert property (@(posedge clk) disable iff (i_reset)
        !(i_frame_done && i_scan_done));

    // Done pulses only come from the current owner
    a_done_owner: assert property (@(posedge clk) disable iff (i_reset)
        (i_frame_done |-> o_eng_grant) and (i_scan_done |-> o_scan_grant));

endmodule

// ==== hw/conv_scatter_engine.sv ====
`timescale 1ns/100ps
`include "conv_defines.svh"

module conv_scatter_engine (
    input  logic                       clk,
    input  logic                       i_reset,
    input  logic                       i_in_valid,
    input  conv_pkg::feature_t         i_in,
    output logic                       o_in_ready,
    input  logic                       i_grant,
    output logic [`CONV_WT_ADDR_W-1:0] o_wt_addr,
    input  logic [`CONV_DATA_W-1:0]    i_wt_data,
    output conv_pkg::acc_rd_t          o_acc_rd,
    output conv_pkg::acc_wr_t          o_acc_wr,
    input  logic [`CONV_DATA_W-1:0]    i_acc_data,
    output logic                       o_frame_done
);
    import conv_pkg::*;

    localparam int DATA_W   = `CONV_DATA_W;
    localparam int COORD_W  = `CONV_COORD_W;
    localparam int ACC_AW   = `CONV_ACC_ADDR_W;
    localparam int OUT_SIZE = `CONV_OUT_SIZE;
    localparam int OUT_AREA = OUT_SIZE * OUT_SIZE;

    engine_state_e state;
    feature_t      feat_q;
    logic          in_ready;

    logic [`CONV_CH_W-1:0]   oc;
    logic [`CONV_KOFF_W-1:0] kx;
    logic [`CONV_KOFF_W-1:0] ky;

    logic [COORD_W-1:0]         ox;
    logic [COORD_W-1:0]         oy;
    logic                       in_grid;
    logic                       last_pair;
    logic                       last_feat;
    logic signed [2*DATA_W-1:0] prod_full;
    logic signed [2*DATA_W-1:0] prod_shift;
    logic [DATA_W-1:0]          addend;
    logic [ACC_AW-1:0]          acc_addr;

    // Output position this kernel tap lands on
    assign ox = feat_q.x - COORD_W'(kx);
    assign oy = feat_q.y - COORD_W'(ky);
    assign in_grid = (feat_q.x >= COORD_W'(kx)) && (ox < OUT_SIZE)
                  && (feat_q.y >= COORD_W'(ky)) && (oy < OUT_SIZE);

    assign acc_addr  = ACC_AW'(oc * OUT_AREA + ox * OUT_SIZE + oy);
    assign o_wt_addr = {oc, feat_q.ch, kx, ky};

    // Fixed point multiply with arithmetic shift and truncation
    assign prod_full  = $signed(i_wt_data) * $signed(feat_q.data);
    assign prod_shift = prod_full >>> `CONV_FRAC_W;
    assign addend     = in_grid ? prod_shift[DATA_W-1:0] : '0;

    assign last_pair = (oc == `CONV_OUT_DEPTH - 1) && (kx == `CONV_KERNEL - 1)
                    && (ky == `CONV_KERNEL - 1);
    assign last_feat = (feat_q.ch == `CONV_IN_DEPTH - 1) && (feat_q.x == `CONV_IN_SIZE - 1)
                    && (feat_q.y == `CONV_IN_SIZE - 1);

    assign o_in_ready = in_ready;

    assign o_acc_rd.en   = (state == ENG_READ);
    assign o_acc_rd.addr = acc_addr;

    // Read data and weight both arrive in ENG_WRITE
    assign o_acc_wr.en   = (state == ENG_WRITE);
    assign o_acc_wr.addr = acc_addr;
    assign o_acc_wr.data = i_acc_data + addend;

    assign o_frame_done = (state == ENG_NEXT) && last_pair && last_feat;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state    <= ENG_RECV;
            in_ready <= 1'b0;
            oc       <= '0;
            kx       <= '0;
            ky       <= '0;
        end else begin
            case (state)
                ENG_RECV: begin
                    if (i_in_valid && in_ready) begin
                        in_ready <= 1'b0;
                        oc       <= '0;
                        kx       <= '0;
                        ky       <= '0;
                        state    <= ENG_READ;
                    end else if (i_grant) begin
                        // Stays low while the scanner holds the memory
                        in_ready <= 1'b1;
                    end
                end
                ENG_READ: begin
                    state <= ENG_WRITE;
                end
                ENG_WRITE: begin
                    state <= ENG_NEXT;
                end
                ENG_NEXT: begin
                    if (last_pair) begin
                        state <= ENG_RECV;
                    end else begin
                        state <= ENG_READ;
                        if (ky == `CONV_KERNEL - 1) begin
                            ky <= '0;
                            if (kx == `CONV_KERNEL - 1) begin
                                kx <= '0;
                                oc <= oc + 1'b1;
                            end else begin
                                kx <= kx + 1'b1;
                            end
                        end else begin
                            ky <= ky + 1'b1;
                        end
                    end
                end
                default: state <= ENG_RECV;
            endcase
        end
    end

    // Feature payload register
    always_ff @(posedge clk) begin
        if (state == ENG_RECV && i_in_valid && in_ready) begin
            feat_q <= i_in;
        end
    end

    // Sender must hold the feature until it is taken
    a_in_hold: assert property (@(posedge clk) disable iff (i_reset)
        (i_in_valid && !o_in_ready) |=> (i_in_valid && $stable(i_in)));

endmodule

// ==== hw/conv_pool_scanner.sv ====
`timescale 1ns/100ps
`include "conv_defines.svh"

module conv_pool_scanner (
    input  logic                    clk,
    input  logic                    i_reset,
    input  logic                    i_grant,
    output conv_pkg::acc_rd_t       o_acc_rd,
    output conv_pkg::acc_wr_t       o_acc_wr,
    input  logic [`CONV_DATA_W-1:0] i_acc_data,
    output logic                    o_out_valid,
    output conv_pkg::pool_out_t     o_out,
    input  logic                    i_out_ready,
    output logic                    o_scan_done
);
    import conv_pkg::*;

    localparam int COORD_W  = `CONV_COORD_W;
    localparam int ACC_AW   = `CONV_ACC_ADDR_W;
    localparam int OUT_SIZE = `CONV_OUT_SIZE;
    localparam int OUT_AREA = OUT_SIZE * OUT_SIZE;
    localparam int POOL_W   = $clog2(`CONV_POOL);

    scan_state_e state;

    logic [`CONV_CH_W-1:0]   ch;
    logic [COORD_W-1:0]      wx;
    logic [COORD_W-1:0]      wy;
    logic [POOL_W-1:0]       px;
    logic [POOL_W-1:0]       py;
    logic [`CONV_DATA_W-1:0] max_q;

    logic [COORD_W-1:0] ex;
    logic [COORD_W-1:0] ey;
    logic [ACC_AW-1:0]  acc_addr;
    logic               last_tap;
    logic               last_win;

    // Entry inside the current window
    assign ex       = COORD_W'(wx * `CONV_POOL + px);
    assign ey       = COORD_W'(wy * `CONV_POOL + py);
    assign acc_addr = ACC_AW'(ch * OUT_AREA + ex * OUT_SIZE + ey);

    assign last_tap = (px == `CONV_POOL - 1) && (py == `CONV_POOL - 1);
    assign last_win = (ch == `CONV_OUT_DEPTH - 1) && (wx == `CONV_POOL_SIZE - 1)
                   && (wy == `CONV_POOL_SIZE - 1);

    assign o_acc_rd.en   = (state == SCAN_READ);
    assign o_acc_rd.addr = acc_addr;

    // Clear behind the read so the next frame starts at zero
    assign o_acc_wr.en   = (state == SCAN_CLEAR);
    assign o_acc_wr.addr = acc_addr;
    assign o_acc_wr.data = '0;

    assign o_out_valid = (state == SCAN_SEND);
    assign o_out.data  = max_q;
    assign o_out.ch    = ch;
    assign o_out.x     = wx;
    assign o_out.y     = wy;

    assign o_scan_done = (state == SCAN_SEND) && i_out_ready && last_win;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= SCAN_IDLE;
            ch    <= '0;
            wx    <= '0;
            wy    <= '0;
            px    <= '0;
            py    <= '0;
            max_q <= '0;
        end else begin
            case (state)
                SCAN_IDLE: begin
                    ch    <= '0;
                    wx    <= '0;
                    wy    <= '0;
                    px    <= '0;
                    py    <= '0;
                    max_q <= '0;
                    if (i_grant) begin
                        state <= SCAN_READ;
                    end
                end
                SCAN_READ: begin
                    state <= SCAN_CLEAR;
                end
                SCAN_CLEAR: begin
                    // ReLU folds into the max since max_q starts at zero
                    if (!i_acc_data[`CONV_DATA_W-1] && (i_acc_data > max_q)) begin
                        max_q <= i_acc_data;
                    end
                    if (py == `CONV_POOL - 1) begin
                        py <= '0;
                        px <= (px == `CONV_POOL - 1) ? '0 : px + 1'b1;
                    end else begin
                        py <= py + 1'b1;
                    end
                    state <= last_tap ? SCAN_SEND : SCAN_READ;
                end
                SCAN_SEND: begin
                    if (i_out_ready) begin
                        max_q <= '0;
                        if (last_win) begin
                            state <= SCAN_IDLE;
                        end else begin
                            state <= SCAN_READ;
                            if (wy == `CONV_POOL_SIZE - 1) begin
                                wy <= '0;
                                if (wx == `CONV_POOL_SIZE - 1) begin
                                    wx <= '0;
                                    ch <= ch + 1'b1;
                                end else begin
                                    wx <= wx + 1'b1;
                                end
                            end else begin
                                wy <= wy + 1'b1;
                            end
                        end
                    end
                end
                default: state <= SCAN_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/conv_layer_top.sv ====
`timescale 1ns/100ps
`include "conv_defines.svh"

module conv_layer_top (
    input  logic                 clk,
    input  logic                 i_reset,
    input  logic                 i_wt_valid,
    input  conv_pkg::weight_wr_t i_wt,
    input  logic                 i_in_valid,
    input  conv_pkg::feature_t   i_in,
    output logic                 o_in_ready,
    output logic                 o_out_valid,
    output conv_pkg::pool_out_t  o_out,
    input  logic                 i_out_ready
);

    logic [`CONV_WT_ADDR_W-1:0] wt_addr;
    logic [`CONV_DATA_W-1:0]    wt_data;
    logic [`CONV_DATA_W-1:0]    acc_data;

    conv_pkg::acc_rd_t eng_rd;
    conv_pkg::acc_wr_t eng_wr;
    conv_pkg::acc_rd_t scan_rd;
    conv_pkg::acc_wr_t scan_wr;
    conv_pkg::acc_rd_t ram_rd;
    conv_pkg::acc_wr_t ram_wr;

    logic frame_done;
    logic scan_done;
    logic eng_grant;
    logic scan_grant;

    conv_weight_ram u_weight_ram (
        .clk        (clk),
        .i_wt_valid (i_wt_valid),
        .i_wt       (i_wt),
        .i_rd_addr  (wt_addr),
        .o_rd_data  (wt_data)
    );

    conv_acc_ram u_acc_ram (
        .clk       (clk),
        .i_rd      (ram_rd),
        .i_wr      (ram_wr),
        .o_rd_data (acc_data)
    );

    conv_acc_arbiter u_acc_arbiter (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_eng_rd     (eng_rd),
        .i_eng_wr     (eng_wr),
        .i_scan_rd    (scan_rd),
        .i_scan_wr    (scan_wr),
        .i_frame_done (frame_done),
        .i_scan_done  (scan_done),
        .o_eng_grant  (eng_grant),
        .o_scan_grant (scan_grant),
        .o_ram_rd     (ram_rd),
        .o_ram_wr     (ram_wr)
    );

    conv_scatter_engine u_scatter_engine (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_in_valid   (i_in_valid),
        .i_in         (i_in),
        .o_in_ready   (o_in_ready),
        .i_grant      (eng_grant),
        .o_wt_addr    (wt_addr),
        .i_wt_data    (wt_data),
        .o_acc_rd     (eng_rd),
        .o_acc_wr     (eng_wr),
        .i_acc_data   (acc_data),
        .o_frame_done (frame_done)
    );

    conv_pool_scanner u_pool_scanner (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_grant     (scan_grant),
        .o_acc_rd    (scan_rd),
        .o_acc_wr    (scan_wr),
        .i_acc_data  (acc_data),
        .o_out_valid (o_out_valid),
        .o_out       (o_out),
        .i_out_ready (i_out_ready),
        .o_scan_done (scan_done)
    );

endmodule

// ==== tb/conv_layer_tb.sv ====
`timescale 1ns/100ps
`include "conv_defines.svh"

module conv_layer_tb;
    import conv_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int DATA_W      = `CONV_DATA_W;
    localparam int CH_W        = `CONV_CH_W;
    localparam int COORD_W     = `CONV_COORD_W;
    localparam int KOFF_W      = `CONV_KOFF_W;
    localparam int IN_SIZE     = `CONV_IN_SIZE;
    localparam int IN_DEPTH    = `CONV_IN_DEPTH;
    localparam int KERNEL      = `CONV_KERNEL;
    localparam int OUT_DEPTH   = `CONV_OUT_DEPTH;
    localparam int POOL        = `CONV_POOL;
    localparam int POOL_SIZE   = `CONV_POOL_SIZE;
    localparam int NUM_INPUTS  = IN_DEPTH * IN_SIZE * IN_SIZE;
    localparam int NUM_PAIRS   = OUT_DEPTH * KERNEL * KERNEL;
    localparam int NUM_WEIGHTS = OUT_DEPTH * IN_DEPTH * KERNEL * KERNEL;
    localparam int NUM_RESULTS = OUT_DEPTH * POOL_SIZE * POOL_SIZE;
    localparam int NUM_FRAMES  = 4;

    // Engine cycles per input plus sweep cycles stretched by back-pressure
    localparam int WD_CYCLES = 2 * (NUM_FRAMES * NUM_INPUTS * (NUM_PAIRS * 3 + 2)
                             + NUM_FRAMES * NUM_WEIGHTS
                             + NUM_FRAMES * NUM_RESULTS * (2 * POOL * POOL + 1) * 4)
                             + 1000;

    localparam int ZERO_DATA     = 0;
    localparam int RANDOM_DATA   = 1;
    localparam int POSITIVE_DATA = 2;

    logic       clk;
    logic       i_reset;
    logic       i_wt_valid;
    weight_wr_t i_wt;
    logic       i_in_valid;
    feature_t   i_in;
    logic       o_in_ready;
    logic       o_out_valid;
    pool_out_t  o_out;
    logic       i_out_ready;

    logic [DATA_W-1:0] wt_mem [OUT_DEPTH][IN_DEPTH][KERNEL][KERNEL];
    logic [DATA_W-1:0] feat_mem [IN_DEPTH][IN_SIZE][IN_SIZE];
    pool_out_t         expected_q [$];

    int data_errors;
    int hs_errors;
    int results_done;
    int frames_sent;
    bit stall_en;

    conv_layer_top u_conv_layer_top (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_wt_valid  (i_wt_valid),
        .i_wt        (i_wt),
        .i_in_valid  (i_in_valid),
        .i_in        (i_in),
        .o_in_ready  (o_in_ready),
        .o_out_valid (o_out_valid),
        .o_out       (o_out),
        .i_out_ready (i_out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Q16.15 product shifted right arithmetically and cut to one word
    function automatic logic [DATA_W-1:0] fx_mul(input logic [DATA_W-1:0] a,
                                                 input logic [DATA_W-1:0] b);
        logic signed [2*DATA_W-1:0] prod;
        prod = $signed(a) * $signed(b);
        prod = prod >>> `CONV_FRAC_W;
        return prod[DATA_W-1:0];
    endfunction

    function automatic logic [DATA_W-1:0] conv_ref(input int oc, input int x, input int y);
        logic [DATA_W-1:0] sum;
        int ic;
        int kx;
        int ky;
        sum = '0;
        for (ic = 0; ic < IN_DEPTH; ic++) begin
            for (kx = 0; kx < KERNEL; kx++) begin
                for (ky = 0; ky < KERNEL; ky++) begin
                    sum = sum + fx_mul(wt_mem[oc][ic][kx][ky], feat_mem[ic][x+kx][y+ky]);
                end
            end
        end
        return sum;
    endfunction

    // Window max with a floor at zero
    function automatic logic [DATA_W-1:0] pool_ref(input int ch, input int wx, input int wy);
        logic [DATA_W-1:0] best;
        logic [DATA_W-1:0] v;
        int px;
        int py;
        best = '0;
        for (px = 0; px < POOL; px++) begin
            for (py = 0; py < POOL; py++) begin
                v = conv_ref(ch, wx * POOL + px, wy * POOL + py);
                if ($signed(v) > $signed(best)) begin
                    best = v;
                end
            end
        end
        return best;
    endfunction

    task automatic fill_weights(input bit negative);
        int oc;
        int ic;
        int kx;
        int ky;
        for (oc = 0; oc < OUT_DEPTH; oc++) begin
            for (ic = 0; ic < IN_DEPTH; ic++) begin
                for (kx = 0; kx < KERNEL; kx++) begin
                    for (ky = 0; ky < KERNEL; ky++) begin
                        if (negative) begin
                            wt_mem[oc][ic][kx][ky] = -(int'($urandom % 65536) + 1);
                        end else begin
                            wt_mem[oc][ic][kx][ky] = int'($urandom % 131073) - 65536;
                        end
                    end
                end
            end
        end
    endtask

    task automatic fill_features(input int kind);
        int ch;
        int x;
        int y;
        for (ch = 0; ch < IN_DEPTH; ch++) begin
            for (x = 0; x < IN_SIZE; x++) begin
                for (y = 0; y < IN_SIZE; y++) begin
                    if (kind == ZERO_DATA) begin
                        feat_mem[ch][x][y] = '0;
                    end else if (kind == POSITIVE_DATA) begin
                        feat_mem[ch][x][y] = int'($urandom % 65536) + 1;
                    end else begin
                        feat_mem[ch][x][y] = int'($urandom % 131073) - 65536;
                    end
                end
            end
        end
    endtask

    task automatic load_weights();
        int oc;
        int ic;
        int kx;
        int ky;
        for (oc = 0; oc < OUT_DEPTH; oc++) begin
            for (ic = 0; ic < IN_DEPTH; ic++) begin
                for (kx = 0; kx < KERNEL; kx++) begin
                    for (ky = 0; ky < KERNEL; ky++) begin
                        @(negedge clk);
                        i_wt_valid  = 1'b1;
                        i_wt.data   = wt_mem[oc][ic][kx][ky];
                        i_wt.out_ch = CH_W'(oc);
                        i_wt.in_ch  = CH_W'(ic);
                        i_wt.kx     = KOFF_W'(kx);
                        i_wt.ky     = KOFF_W'(ky);
                    end
                end
            end
        end
        @(negedge clk);
        i_wt_valid = 1'b0;
    endtask

    task automatic push_expected();
        pool_out_t r;
        int ch;
        int wx;
        int wy;
        for (ch = 0; ch < OUT_DEPTH; ch++) begin
            for (wx = 0; wx < POOL_SIZE; wx++) begin
                for (wy = 0; wy < POOL_SIZE; wy++) begin
                    r.data = pool_ref(ch, wx, wy);
                    r.ch   = CH_W'(ch);
                    r.x    = COORD_W'(wx);
                    r.y    = COORD_W'(wy);
                    expected_q.push_back(r);
                end
            end
        end
    endtask

    task automatic send_features();
        feature_t f;
        bit first;
        int ch;
        int x;
        int y;
        first = 1'b1;
        for (ch = 0; ch < IN_DEPTH; ch++) begin
            for (x = 0; x < IN_SIZE; x++) begin
                for (y = 0; y < IN_SIZE; y++) begin
                    f.data = feat_mem[ch][x][y];
                    f.ch   = CH_W'(ch);
                    f.x    = COORD_W'(x);
                    f.y    = COORD_W'(y);
                    @(negedge clk);
                    i_in_valid = 1'b1;
                    i_in       = f;
                    while (o_in_ready !== 1'b1) begin
                        @(negedge clk);
                    end
                    // Engine stays blocked until the previous sweep has sent everything
                    if (first && (results_done != frames_sent * NUM_RESULTS
                                  || o_out_valid === 1'b1)) begin
                        hs_errors++;
                        $display("Input ready rose at %0t with only %0d of %0d results sent",
                                 $time, results_done, frames_sent * NUM_RESULTS);
                    end
                    first = 1'b0;
                end
            end
        end
        @(negedge clk);
        i_in_valid = 1'b0;
        frames_sent++;
    endtask

    // Drives back-pressure and checks every result that transfers
    initial begin
        pool_out_t held;
        pool_out_t exp;
        bit        hold_pending;
        i_out_ready  = 1'b1;
        hold_pending = 1'b0;
        forever begin
            @(negedge clk);
            if (!i_reset) begin
                if (hold_pending) begin
                    if (o_out_valid !== 1'b1 || o_out !== held) begin
                        data_errors++;
                        $display("error at %0t: result changed or dropped while ready was low",
                                 $time);
                    end
                end
                hold_pending = 1'b0;
                i_out_ready  = stall_en ? (($urandom % 3) != 0) : 1'b1;
                if (o_out_valid === 1'b1 && i_out_ready) begin
                    results_done++;
                    if (expected_q.size() == 0) begin
                        data_errors++;
                        $display("Extra result at %0t when none was expected", $time);
                    end else begin
                        exp = expected_q.pop_front();
                        if (o_out !== exp) begin
                            data_errors++;
                            $display("error at %0t: got %0d/%0d/%0d %h, expected %0d/%0d/%0d %h",
                                     $time, o_out.ch, o_out.x, o_out.y, o_out.data,
                                     exp.ch, exp.x, exp.y, exp.data);
                        end
                    end
                end else if (o_out_valid === 1'b1) begin
                    held         = o_out;
                    hold_pending = 1'b1;
                end
            end
        end
    end

    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d clock cycles", WD_CYCLES);
        $display("Errors: %0d data, %0d handshake", data_errors, hs_errors);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hf4c0_037c));
        data_errors  = 0;
        hs_errors    = 0;
        results_done = 0;
        frames_sent  = 0;
        stall_en     = 1'b0;
        i_reset      = 1'b1;
        i_wt_valid   = 1'b0;
        i_wt         = '0;
        i_in_valid   = 1'b0;
        i_in         = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        i_reset = 1'b0;
        @(negedge clk);
        if (o_in_ready !== 1'b1 || o_out_valid !== 1'b0) begin
            data_errors++;
            $display("error at %0t: after reset o_in_ready=%b o_out_valid=%b, expected 1 and 0",
                     $time, o_in_ready, o_out_valid);
        end

        // Zero frame whose sweep clears the unknown power-up contents of the accumulator
        @(posedge clk);
        fill_weights(1'b0);
        load_weights();
        fill_features(ZERO_DATA);
        push_expected();
        send_features();

        @(posedge clk);
        fill_features(RANDOM_DATA);
        push_expected();
        send_features();

        // Second random frame under back-pressure
        @(posedge clk);
        stall_en = 1'b1;
        fill_features(RANDOM_DATA);
        push_expected();
        send_features();

        // Negative weights on positive inputs floor every window at zero
        wait (results_done == frames_sent * NUM_RESULTS);
        @(posedge clk);
        fill_weights(1'b1);
        load_weights();
        fill_features(POSITIVE_DATA);
        push_expected();
        send_features();

        wait (results_done == frames_sent * NUM_RESULTS);
        repeat (10) @(negedge clk);
        if (expected_q.size() != 0) begin
            data_errors++;
            $display("Results missing: %0d expected results never arrived", expected_q.size());
        end
        if (o_out_valid !== 1'b0) begin
            hs_errors++;
            $display("Output valid still high after the last frame was swept");
        end

        $display("Errors: %0d data, %0d handshake", data_errors, hs_errors);
        if (data_errors == 0 && hs_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+hw
hw/conv_pkg.sv
hw/conv_weight_ram.sv
hw/conv_acc_ram.sv
hw/conv_acc_arbiter.sv
hw/conv_scatter_engine.sv
hw/conv_pool_scanner.sv
hw/conv_layer_top.sv
tb/conv_layer_tb.sv
